//--- verif/decode_patterns.txt
# bundle pc priv stall | slot0: unit alu rd wr imm ev code | slot1: same | slot1_valid
# all fields hex, bundle upper word is slot 1 for an even pc
fff0811300500093 00000100 1 0 1 0 01 1 00000005 0 0 1 0 02 1 ffffffff 0 0 1
40208233002081b3 00000102 1 0 1 0 03 1 00000000 0 0 1 8 04 1 00000000 0 0 1
4020d3334030d293 00000104 1 0 1 d 05 1 00000403 0 0 1 d 06 1 00000000 0 0 1
fe20ae230080a383 00000106 1 1 3 2 07 1 00000008 0 0 4 2 1c 0 fffffffc 0 0 1
fe209ce300208863 00000108 1 1 2 0 10 0 00000010 0 0 2 1 19 0 fffffff8 0 0 1
00008067001000ef 0000010a 1 1 2 0 01 1 00000800 0 0 2 0 00 0 00000000 0 0 1
fffff49712345437 0000010c 1 1 1 5 08 1 12345000 0 0 1 7 09 1 fffff000 0 0 1
300095730ff0000f 0000010e 1 1 6 0 00 0 00000000 0 0 5 1 0a 1 00000300 0 0 1
0010007300000073 00000110 1 1 0 0 00 0 00000000 1 b 0 0 00 0 00000000 1 3 1
0050009330200073 00000112 1 0 0 0 00 0 00000000 0 0 1 0 01 1 00000005 0 0 1
002081b300500093 00000115 1 1 1 0 03 1 00000000 0 0 0 0 00 0 00000000 0 0 0
0000e38300000000 00000116 1 1 0 0 00 0 00000000 1 2 0 6 07 0 00000000 1 2 1
40209233022081b3 00000118 1 1 0 0 03 0 00000000 1 2 0 9 04 0 00000000 1 2 1
000090670000007f 0000011a 1 1 0 0 00 0 00000000 1 2 0 1 00 0 00000000 1 2 1
0020a0630020b023 0000011c 1 1 0 3 00 0 00000000 1 2 0 2 00 0 00000000 1 2 1
0080a38310500073 0000011e 1 0 0 0 00 0 00000000 1 2 3 2 07 1 00000008 0 0 1
3020007300000073 00000200 0 0 0 0 00 0 00000000 1 8 0 0 00 0 00000000 1 2 1
0010007300000073 00000203 0 1 0 0 00 0 00000000 1 3 0 0 00 0 00000000 0 0 0
fe20ae230080a383 00000204 0 1 3 2 07 1 00000008 0 0 4 2 1c 0 fffffffc 0 0 1
fffff49712345437 00000206 0 1 1 5 08 1 12345000 0 0 1 7 09 1 fffff000 0 0 1
00008067001000ef 00000208 0 1 2 0 01 1 00000800 0 0 2 0 00 0 00000000 0 0 1
fe209ce300208863 0000020b 0 1 2 1 19 0 fffffff8 0 0 0 0 00 0 00000000 0 0 0
fff0811300500093 0000020c 0 1 1 0 01 1 00000005 0 0 1 0 02 1 ffffffff 0 0 1
4030d29340208233 0000020e 0 0 1 8 04 1 00000000 0 0 1 d 05 1 00000403 0 0 1

//--- dual_decode.f
+incdir+design
design/dec_pkg.sv
design/fetch_skid_buffer.sv
design/imm_gen.sv
design/rv_slot_decoder.sv
design/decode_bundle_reg.sv
design/dual_decode.sv
verif/tb_dual_decode.sv

//--- Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing -f dual_decode.f --top-module tb_dual_decode -o sim_dual_decode

run: compile
	./obj_dir/sim_dual_decode

clean:
	rm -rf obj_dir

//--- verif/tb_dual_decode.sv
`timescale 1ns/1ps
`include "dec_cfg.svh"

module tb_dual_decode;
    import dec_pkg::*;

    logic                cpu_clk_i;
    logic                rst_n_i;
    logic                flush_i;
    logic                priv_machine_i;
    logic                fetch_valid_i;
    logic [`FETCH_W-1:0] fetch_bundle_i;
    logic [`PC_W-1:0]    fetch_pc_i;
    logic                rn_busy_i;
    logic                busy_o, valid_o, slot1_valid_o;
    logic [`PC_W-1:0]    bundle_pc_o;
    unit_e               ins0_unit_o, ins1_unit_o;
    logic [3:0]          ins0_alu_op_o, ins1_alu_op_o;
    logic [`REG_AW-1:0]  ins0_rs1_o, ins0_rs2_o, ins0_rd_o;
    logic [`REG_AW-1:0]  ins1_rs1_o, ins1_rs2_o, ins1_rd_o;
    logic                ins0_rd_write_o, ins1_rd_write_o;
    logic [`XLEN-1:0]    ins0_imm_o, ins1_imm_o;
    logic                ins0_excp_valid_o, ins1_excp_valid_o;
    excp_code_e          ins0_excp_code_o, ins1_excp_code_o;

    // Pattern table, one entry per line of the data file
    logic [63:0] pat_bundle [64];
    logic [31:0] pat_pc [64];
    logic        pat_priv [64];
    logic        pat_stall [64];
    unit_e       exp_unit [64][2];
    logic [3:0]  exp_alu [64][2];
    logic [4:0]  exp_rd [64][2];
    logic        exp_wr [64][2];
    logic [31:0] exp_imm [64][2];
    logic        exp_ev [64][2];
    excp_code_e  exp_code [64][2];
    logic        exp_s1v [64];

    int     n_pat;
    int     exp_q[$];
    int     seed;
    int     cyc;
    int     acc_cyc;
    int     idx;
    bit     loaded;
    bit     first_seen;
    bit     flush_phase;
    bit     hold_valid;
    logic [`PC_W-1:0] held_pc;
    logic [31:0]      held_imm0;
    unit_e            held_unit0;

    dual_decode u_dual_decode (.*);

    initial cpu_clk_i = 1'b0;
    always #20 cpu_clk_i = ~cpu_clk_i;

    always @(posedge cpu_clk_i) cyc <= cyc + 1;

    task automatic fail_run();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_unit(input string name, input unit_e got, input unit_e exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %s, expected %s",
                     $time, name, got.name(), exp.name());
            fail_run();
        end
    endtask

    task automatic check_excp(input string name, input excp_code_e got,
                              input excp_code_e exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            fail_run();
        end
    endtask

    // Word a slot holds, upper word for slot 1 or for an odd PC
    function automatic logic [31:0] slot_insn(input int i, input int s);
        if (s == 1 || pat_pc[i][0]) begin
            return pat_bundle[i][63:32];
        end
        return pat_bundle[i][31:0];
    endfunction

    task automatic check_slot(input int s, input int i, input unit_e unit,
                              input logic [3:0] alu, input logic [4:0] rs1,
                              input logic [4:0] rs2, input logic [4:0] rd, input logic wr,
                              input logic [31:0] imm, input logic ev, input excp_code_e code);
        string       p;
        logic [31:0] insn;
        p    = $sformatf("pattern %0d ins%0d_", i, s);
        insn = slot_insn(i, s);
        check_unit({p, "unit"}, unit, exp_unit[i][s]);
        check_word({p, "alu_op"}, {28'd0, alu}, {28'd0, exp_alu[i][s]});
        // Source registers sit at the standard RISC-V field positions
        check_word({p, "rs1"}, {27'd0, rs1}, {27'd0, insn[19:15]});
        check_word({p, "rs2"}, {27'd0, rs2}, {27'd0, insn[24:20]});
        check_word({p, "rd"}, {27'd0, rd}, {27'd0, exp_rd[i][s]});
        check_bit({p, "rd_write"}, wr, exp_wr[i][s]);
        check_word({p, "imm"}, imm, exp_imm[i][s]);
        check_bit({p, "excp_valid"}, ev, exp_ev[i][s]);
        check_excp({p, "excp_code"}, code, exp_code[i][s]);
    endtask

    task automatic read_patterns();
        int          fd;
        int          n;
        string       line;
        logic [63:0] b;
        logic [31:0] f [18];
        fd = $fopen("verif/decode_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file verif/decode_patterns.txt");
            fail_run();
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#") continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        b, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                        f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
            if (n != 19) begin
                $display("Pattern line %0d is malformed", n_pat);
                fail_run();
            end
            pat_bundle[n_pat] = b;
            pat_pc[n_pat]     = f[0];
            pat_priv[n_pat]   = f[1][0];
            pat_stall[n_pat]  = f[2][0];
            for (int s = 0; s < 2; s++) begin
                exp_unit[n_pat][s] = unit_e'(f[3 + 7*s][2:0]);
                exp_alu[n_pat][s]  = f[4 + 7*s][3:0];
                exp_rd[n_pat][s]   = f[5 + 7*s][4:0];
                exp_wr[n_pat][s]   = f[6 + 7*s][0];
                exp_imm[n_pat][s]  = f[7 + 7*s];
                exp_ev[n_pat][s]   = f[8 + 7*s][0];
                exp_code[n_pat][s] = excp_code_e'(f[9 + 7*s][3:0]);
            end
            exp_s1v[n_pat] = f[17][0];
            n_pat++;
        end
        $fclose(fd);
    endtask

    // Wait until every accepted bundle has reached rename
    task automatic drain();
        fetch_valid_i <= 1'b0;
        rn_busy_i     <= 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge cpu_clk_i);
        end
    endtask

    // Output monitor and scoreboard
    always @(posedge cpu_clk_i) begin
        if (rst_n_i) begin
            if (flush_phase && valid_o) begin
                $display("A flushed bundle still reached the decode outputs");
                fail_run();
            end
            if (hold_valid) begin
                check_bit("valid_o during stall", valid_o, 1'b1);
                check_word("bundle_pc_o during stall", {2'b0, bundle_pc_o}, {2'b0, held_pc});
                check_word("ins0_imm_o during stall", ins0_imm_o, held_imm0);
                check_unit("ins0_unit_o during stall", ins0_unit_o, held_unit0);
            end
            if (valid_o && !rn_busy_i) begin
                if (exp_q.size() == 0) begin
                    $display("valid_o was high with no bundle outstanding");
                    fail_run();
                end
                idx = exp_q.pop_front();
                if (!first_seen) begin
                    first_seen = 1'b1;
                    // Skid register, then output register
                    check_word("first bundle latency", cyc - acc_cyc, 32'd2);
                end
                check_word("bundle_pc_o", {2'b0, bundle_pc_o}, pat_pc[idx]);
                check_bit("slot1_valid_o", slot1_valid_o, exp_s1v[idx]);
                check_slot(0, idx, ins0_unit_o, ins0_alu_op_o, ins0_rs1_o, ins0_rs2_o,
                           ins0_rd_o, ins0_rd_write_o, ins0_imm_o, ins0_excp_valid_o,
                           ins0_excp_code_o);
                if (exp_s1v[idx]) begin
                    check_slot(1, idx, ins1_unit_o, ins1_alu_op_o, ins1_rs1_o, ins1_rs2_o,
                               ins1_rd_o, ins1_rd_write_o, ins1_imm_o, ins1_excp_valid_o,
                               ins1_excp_code_o);
                end
            end
            hold_valid = valid_o && rn_busy_i && !flush_i;
            held_pc    = bundle_pc_o;
            held_imm0  = ins0_imm_o;
            held_unit0 = ins0_unit_o;
        end
    end

    initial begin
        wait (loaded);
        repeat (n_pat * 20 + 200) @(posedge cpu_clk_i);
        $display("Timeout: decoded bundles stopped arriving at the outputs");
        fail_run();
    end

    initial begin
        bit accepted;
        rst_n_i        = 1'b0;
        flush_i        = 1'b0;
        priv_machine_i = 1'b1;
        fetch_valid_i  = 1'b0;
        fetch_bundle_i = '0;
        fetch_pc_i     = '0;
        rn_busy_i      = 1'b0;
        cyc            = 0;
        seed           = 32'h7bb1d70c;
        read_patterns();
        loaded = 1'b1;
        repeat (4) @(posedge cpu_clk_i);
        rst_n_i <= 1'b1;
        @(posedge cpu_clk_i);
        check_bit("valid_o after reset", valid_o, 1'b0);
        check_bit("busy_o after reset", busy_o, 1'b0);

        for (int i = 0; i < n_pat; i++) begin
            // Privilege is sampled at decode, so let older bundles leave first
            if (pat_priv[i] !== priv_machine_i) begin
                drain();
                priv_machine_i <= pat_priv[i];
            end
            fetch_valid_i  <= 1'b1;
            fetch_bundle_i <= pat_bundle[i];
            fetch_pc_i     <= pat_pc[i][`PC_W-1:0];
            accepted = 1'b0;
            while (!accepted) begin
                @(posedge cpu_clk_i);
                if (fetch_valid_i && !busy_o) begin
                    accepted = 1'b1;
                    if (i == 0) acc_cyc = cyc;
                    exp_q.push_back(i);
                end
                rn_busy_i <= pat_stall[i] && ($random(seed) & 1);
            end
        end
        drain();
        repeat (2) @(posedge cpu_clk_i);

        // Load the output register, fill both skid entries under a stall, then flush
        fetch_valid_i  <= 1'b1;
        fetch_bundle_i <= pat_bundle[0];
        fetch_pc_i     <= pat_pc[0][`PC_W-1:0];
        repeat (2) @(posedge cpu_clk_i);
        rn_busy_i <= 1'b1;
        repeat (2) @(posedge cpu_clk_i);
        check_bit("valid_o before flush", valid_o, 1'b1);
        check_bit("busy_o with both entries full", busy_o, 1'b1);
        flush_i       <= 1'b1;
        fetch_valid_i <= 1'b0;
        @(posedge cpu_clk_i);
        flush_i     <= 1'b0;
        rn_busy_i   <= 1'b0;
        flush_phase <= 1'b1;
        repeat (6) @(posedge cpu_clk_i);
        check_bit("valid_o after flush", valid_o, 1'b0);
        check_bit("busy_o after flush", busy_o, 1'b0);

        $display(">>> PASS");
        $finish;
    end

endmodule

//--- design/dual_decode.sv
`timescale 1ns/1ps
`include "dec_cfg.svh"

module dual_decode (
    input  logic                cpu_clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                priv_machine_i,
    input  logic                fetch_valid_i,
    input  logic [`FETCH_W-1:0] fetch_bundle_i,
    input  logic [`PC_W-1:0]    fetch_pc_i,
    input  logic                rn_busy_i,
    output logic                busy_o,
    output logic                valid_o,
    output logic [`PC_W-1:0]    bundle_pc_o,
    output logic                slot1_valid_o,
    output dec_pkg::unit_e      ins0_unit_o, ins1_unit_o,
    output logic [3:0]          ins0_alu_op_o, ins1_alu_op_o,
    output logic [`REG_AW-1:0]  ins0_rs1_o, ins0_rs2_o, ins0_rd_o,
    output logic [`REG_AW-1:0]  ins1_rs1_o, ins1_rs2_o, ins1_rd_o,
    output logic                ins0_rd_write_o, ins1_rd_write_o,
    output logic [`XLEN-1:0]    ins0_imm_o, ins1_imm_o,
    output logic                ins0_excp_valid_o, ins1_excp_valid_o,
    output dec_pkg::excp_code_e ins0_excp_code_o, ins1_excp_code_o
);
    import dec_pkg::*;

    logic                sk_valid;
    logic [`FETCH_W-1:0] sk_bundle;
    logic [`PC_W-1:0]    sk_pc;
    logic [`INSN_W-1:0]  insn0;
    logic [`INSN_W-1:0]  insn1;
    logic                slot1_valid;

    unit_e               d0_unit, d1_unit;
    logic [3:0]          d0_alu_op, d1_alu_op;
    logic [`REG_AW-1:0]  d0_rs1, d0_rs2, d0_rd;
    logic [`REG_AW-1:0]  d1_rs1, d1_rs2, d1_rd;
    logic                d0_rd_write, d1_rd_write;
    logic [`XLEN-1:0]    d0_imm, d1_imm;
    logic                d0_excp_valid, d1_excp_valid;
    excp_code_e          d0_excp_code, d1_excp_code;

    fetch_skid_buffer u_skid (
        .cpu_clk_i    (cpu_clk_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .rn_busy_i    (rn_busy_i),
        .in_valid_i   (fetch_valid_i),
        .in_bundle_i  (fetch_bundle_i),
        .in_pc_i      (fetch_pc_i),
        .out_valid_o  (sk_valid),
        .out_bundle_o (sk_bundle),
        .out_pc_o     (sk_pc),
        .busy_o       (busy_o)
    );

    // An odd PC enters mid-bundle, so only the upper word is live
    assign insn0       = sk_pc[0] ? sk_bundle[`FETCH_W-1:`INSN_W] : sk_bundle[`INSN_W-1:0];
    assign insn1       = sk_bundle[`FETCH_W-1:`INSN_W];
    assign slot1_valid = ~sk_pc[0];

    rv_slot_decoder u_dec0 (
        .insn_i (insn0), .priv_machine_i (priv_machine_i),
        .unit_o (d0_unit), .alu_op_o (d0_alu_op),
        .rs1_o (d0_rs1), .rs2_o (d0_rs2), .rd_o (d0_rd),
        .rd_write_o (d0_rd_write), .imm_o (d0_imm),
        .excp_valid_o (d0_excp_valid), .excp_code_o (d0_excp_code)
    );

    rv_slot_decoder u_dec1 (
        .insn_i (insn1), .priv_machine_i (priv_machine_i),
        .unit_o (d1_unit), .alu_op_o (d1_alu_op),
        .rs1_o (d1_rs1), .rs2_o (d1_rs2), .rd_o (d1_rd),
        .rd_write_o (d1_rd_write), .imm_o (d1_imm),
        .excp_valid_o (d1_excp_valid), .excp_code_o (d1_excp_code)
    );

    decode_bundle_reg u_out (
        .cpu_clk_i (cpu_clk_i), .rst_n_i (rst_n_i),
        .flush_i (flush_i), .rn_busy_i (rn_busy_i),
        .in_valid_i (sk_valid), .in_pc_i (sk_pc), .slot1_valid_i (slot1_valid),
        .s0_unit_i (d0_unit), .s0_alu_op_i (d0_alu_op),
        .s0_rs1_i (d0_rs1), .s0_rs2_i (d0_rs2), .s0_rd_i (d0_rd),
        .s0_rd_write_i (d0_rd_write), .s0_imm_i (d0_imm),
        .s0_excp_valid_i (d0_excp_valid), .s0_excp_code_i (d0_excp_code),
        .s1_unit_i (d1_unit), .s1_alu_op_i (d1_alu_op),
        .s1_rs1_i (d1_rs1), .s1_rs2_i (d1_rs2), .s1_rd_i (d1_rd),
        .s1_rd_write_i (d1_rd_write), .s1_imm_i (d1_imm),
        .s1_excp_valid_i (d1_excp_valid), .s1_excp_code_i (d1_excp_code),
        .valid_o (valid_o), .bundle_pc_o (bundle_pc_o), .slot1_valid_o (slot1_valid_o),
        .s0_unit_o (ins0_unit_o), .s0_alu_op_o (ins0_alu_op_o),
        .s0_rs1_o (ins0_rs1_o), .s0_rs2_o (ins0_rs2_o), .s0_rd_o (ins0_rd_o),
        .s0_rd_write_o (ins0_rd_write_o), .s0_imm_o (ins0_imm_o),
        .s0_excp_valid_o (ins0_excp_valid_o), .s0_excp_code_o (ins0_excp_code_o),
        .s1_unit_o (ins1_unit_o), .s1_alu_op_o (ins1_alu_op_o),
        .s1_rs1_o (ins1_rs1_o), .s1_rs2_o (ins1_rs2_o), .s1_rd_o (ins1_rd_o),
        .s1_rd_write_o (ins1_rd_write_o), .s1_imm_o (ins1_imm_o),
        .s1_excp_valid_o (ins1_excp_valid_o), .s1_excp_code_o (ins1_excp_code_o)
    );

endmodule

//--- design/decode_bundle_reg.sv
`timescale 1ns/1ps
`include "dec_cfg.svh"

module decode_bundle_reg (
    input  logic                cpu_clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                rn_busy_i,
    input  logic                in_valid_i,
    input  logic [`PC_W-1:0]    in_pc_i,
    input  logic                slot1_valid_i,
    input  dec_pkg::unit_e      s0_unit_i, s1_unit_i,
    input  logic [3:0]          s0_alu_op_i, s1_alu_op_i,
    input  logic [`REG_AW-1:0]  s0_rs1_i, s0_rs2_i, s0_rd_i,
    input  logic [`REG_AW-1:0]  s1_rs1_i, s1_rs2_i, s1_rd_i,
    input  logic                s0_rd_write_i, s1_rd_write_i,
    input  logic [`XLEN-1:0]    s0_imm_i, s1_imm_i,
    input  logic                s0_excp_valid_i, s1_excp_valid_i,
    input  dec_pkg::excp_code_e s0_excp_code_i, s1_excp_code_i,
    output logic                valid_o,
    output logic [`PC_W-1:0]    bundle_pc_o,
    output logic                slot1_valid_o,
    output dec_pkg::unit_e      s0_unit_o, s1_unit_o,
    output logic [3:0]          s0_alu_op_o, s1_alu_op_o,
    output logic [`REG_AW-1:0]  s0_rs1_o, s0_rs2_o, s0_rd_o,
    output logic [`REG_AW-1:0]  s1_rs1_o, s1_rs2_o, s1_rd_o,
    output logic                s0_rd_write_o, s1_rd_write_o,
    output logic [`XLEN-1:0]    s0_imm_o, s1_imm_o,
    output logic                s0_excp_valid_o, s1_excp_valid_o,
    output dec_pkg::excp_code_e s0_excp_code_o, s1_excp_code_o
);

    logic load_en;

    // Rename takes a bundle on every edge it is not busy
    assign load_en = !rn_busy_i && in_valid_i;

    always_ff @(posedge cpu_clk_i) begin
        if (!rst_n_i || flush_i) begin
            valid_o <= 1'b0;
        end else if (!rn_busy_i) begin
            valid_o <= in_valid_i;
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (load_en) begin
            bundle_pc_o     <= in_pc_i;
            slot1_valid_o   <= slot1_valid_i;
            s0_unit_o       <= s0_unit_i;
            s0_alu_op_o     <= s0_alu_op_i;
            s0_rs1_o        <= s0_rs1_i;
            s0_rs2_o        <= s0_rs2_i;
            s0_rd_o         <= s0_rd_i;
            s0_rd_write_o   <= s0_rd_write_i;
            s0_imm_o        <= s0_imm_i;
            s0_excp_valid_o <= s0_excp_valid_i;
            s0_excp_code_o  <= s0_excp_code_i;
            s1_unit_o       <= s1_unit_i;
            s1_alu_op_o     <= s1_alu_op_i;
            s1_rs1_o        <= s1_rs1_i;
            s1_rs2_o        <= s1_rs2_i;
            s1_rd_o         <= s1_rd_i;
            s1_rd_write_o   <= s1_rd_write_i;
            s1_imm_o        <= s1_imm_i;
            s1_excp_valid_o <= s1_excp_valid_i;
            s1_excp_code_o  <= s1_excp_code_i;
        end
    end

endmodule

//--- design/rv_slot_decoder.sv
`timescale 1ns/1ps
`include "dec_cfg.svh"

module rv_slot_decoder (
    input  logic [`INSN_W-1:0] insn_i,
    input  logic               priv_machine_i,
    output dec_pkg::unit_e     unit_o,
    output logic [3:0]         alu_op_o,
    output logic [`REG_AW-1:0] rs1_o,
    output logic [`REG_AW-1:0] rs2_o,
    output logic [`REG_AW-1:0] rd_o,
    output logic               rd_write_o,
    output logic [`XLEN-1:0]   imm_o,
    output logic               excp_valid_o,
    output dec_pkg::excp_code_e excp_code_o
);
    import dec_pkg::*;

    opcode_e    opc;
    unit_e      unit_raw;
    imm_fmt_e   fmt;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       writes_rd;
    logic       illegal;
    logic       sys_priv;
    logic       is_ecall;
    logic       is_ebreak;
    logic       is_mret;
    logic       alt_op;

    assign opc    = opcode_e'(insn_i[6:2]);
    assign funct3 = insn_i[14:12];
    assign funct7 = insn_i[31:25];

    assign rs1_o = insn_i[19:15];
    assign rs2_o = insn_i[24:20];
    assign rd_o  = insn_i[11:7];

    // Privileged forms are matched on everything above the opcode
    assign is_ecall  = insn_i[31:7] == 25'h0000000;
    assign is_ebreak = insn_i[31:7] == 25'h0002000;
    assign is_mret   = insn_i[31:7] == {12'h302, 13'h0000};

    always_comb begin
        unit_raw  = UNIT_NONE;
        fmt       = IMM_NONE;
        writes_rd = 1'b0;
        illegal   = 1'b0;
        sys_priv  = 1'b0;
        case (opc)
            LOAD: begin
                unit_raw  = UNIT_LOAD;
                fmt       = IMM_I;
                writes_rd = 1'b1;
                illegal   = funct3[2:1] == 2'b11;
            end
            MISC_MEM: unit_raw = UNIT_FENCE;
            OP_IMM: begin
                unit_raw  = UNIT_ALU;
                fmt       = IMM_I;
                writes_rd = 1'b1;
            end
            AUIPC, LUI: begin
                unit_raw  = UNIT_ALU;
                fmt       = IMM_U;
                writes_rd = 1'b1;
            end
            STORE: begin
                unit_raw = UNIT_STORE;
                fmt      = IMM_S;
                illegal  = funct3 > 3'd2;
            end
            OP: begin
                // Base ISA only, SUB and SRA use funct7 0x20
                unit_raw  = UNIT_ALU;
                writes_rd = 1'b1;
                illegal   = !((funct7 == 7'h00) ||
                              ((funct7 == 7'h20) && (funct3 == 3'd0 || funct3 == 3'd5)));
            end
            BRANCH: begin
                unit_raw = UNIT_BRANCH;
                fmt      = IMM_B;
                illegal  = funct3[2:1] == 2'b01;
            end
            JALR: begin
                unit_raw  = UNIT_BRANCH;
                fmt       = IMM_I;
                writes_rd = 1'b1;
                illegal   = funct3 != 3'd0;
            end
            JAL: begin
                unit_raw  = UNIT_BRANCH;
                fmt       = IMM_J;
                writes_rd = 1'b1;
            end
            SYSTEM: begin
                if (funct3 == 3'd0) begin
                    sys_priv = 1'b1;
                    illegal  = !(is_ecall || is_ebreak || is_mret) ||
                               (is_mret && !priv_machine_i);
                end else begin
                    unit_raw  = UNIT_CSR;
                    fmt       = IMM_I;
                    writes_rd = 1'b1;
                end
            end
            default: illegal = 1'b1;
        endcase
        // Compressed or reserved encodings
        if (insn_i[1:0] != 2'b11) begin
            illegal = 1'b1;
        end
    end

    // Bit 30 selects SUB/SRA, and SRAI among the immediate shifts
    assign alt_op   = (opc == OP) || ((opc == OP_IMM) && (funct3 == 3'b101));
    assign alu_op_o = {alt_op & insn_i[30], funct3};

    assign unit_o     = illegal ? UNIT_NONE : unit_raw;
    assign rd_write_o = writes_rd && !illegal && (rd_o != '0);

    assign excp_valid_o = illegal || (sys_priv && (is_ecall || is_ebreak));

    always_comb begin
        if (illegal) begin
            excp_code_o = EXC_ILLEGAL;
        end else if (sys_priv && is_ecall) begin
            excp_code_o = priv_machine_i ? EXC_ECALL_M : EXC_ECALL_U;
        end else if (sys_priv && is_ebreak) begin
            excp_code_o = EXC_BREAKPOINT;
        end else begin
            excp_code_o = EXC_NONE;
        end
    end

    imm_gen u_imm (
        .insn_i (insn_i),
        .fmt_i  (fmt),
        .imm_o  (imm_o)
    );

endmodule

//--- design/imm_gen.sv
`timescale 1ns/1ps
`include "dec_cfg.svh"

module imm_gen (
    input  logic [`INSN_W-1:0] insn_i,
    input  dec_pkg::imm_fmt_e  fmt_i,
    output logic [`XLEN-1:0]   imm_o
);
    import dec_pkg::*;

    logic [`XLEN-1:0] imm_i_type;
    logic [`XLEN-1:0] imm_s_type;
    logic [`XLEN-1:0] imm_b_type;
    logic [`XLEN-1:0] imm_u_type;
    logic [`XLEN-1:0] imm_j_type;
    logic             sign;

    assign sign = insn_i[31];

    assign imm_i_type = {{20{sign}}, insn_i[31:20]};
    assign imm_s_type = {{20{sign}}, insn_i[31:25], insn_i[11:7]};
    // Branch and jump offsets are in halfwords, bit 0 always clear
    assign imm_b_type = {{20{sign}}, insn_i[7], insn_i[30:25], insn_i[11:8], 1'b0};
    assign imm_j_type = {{12{sign}}, insn_i[19:12], insn_i[20], insn_i[30:21], 1'b0};
    assign imm_u_type = {insn_i[31:12], 12'h000};

    always_comb begin
        case (fmt_i)
            IMM_I:   imm_o = imm_i_type;
            IMM_S:   imm_o = imm_s_type;
            IMM_B:   imm_o = imm_b_type;
            IMM_U:   imm_o = imm_u_type;
            IMM_J:   imm_o = imm_j_type;
            default: imm_o = '0;
        endcase
    end

endmodule

//--- design/fetch_skid_buffer.sv
`timescale 1ns/1ps
`include "dec_cfg.svh"

module fetch_skid_buffer (
    input  logic                cpu_clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                rn_busy_i,
    input  logic                in_valid_i,
    input  logic [`FETCH_W-1:0] in_bundle_i,
    input  logic [`PC_W-1:0]    in_pc_i,
    output logic                out_valid_o,
    output logic [`FETCH_W-1:0] out_bundle_o,
    output logic [`PC_W-1:0]    out_pc_o,
    output logic                busy_o
);

    logic                spare_valid;
    logic [`FETCH_W-1:0] spare_bundle;
    logic [`PC_W-1:0]    spare_pc;
    logic                accept;

    // Fetch is only refused while the spare entry is full
    assign accept = in_valid_i & ~spare_valid;
    assign busy_o = spare_valid;

    always_ff @(posedge cpu_clk_i) begin
        if (!rst_n_i || flush_i) begin
            out_valid_o <= 1'b0;
            spare_valid <= 1'b0;
        end else if (!rn_busy_i) begin
            // Main entry drains this edge, spare moves up first
            out_valid_o <= spare_valid | accept;
            spare_valid <= 1'b0;
        end else if (accept) begin
            if (out_valid_o) begin
                spare_valid <= 1'b1;
            end else begin
                out_valid_o <= 1'b1;
            end
        end
    end

    // Payload follows the same steering as the valid bits
    always_ff @(posedge cpu_clk_i) begin
        if (!rn_busy_i) begin
            if (spare_valid) begin
                out_bundle_o <= spare_bundle;
                out_pc_o     <= spare_pc;
            end else if (accept) begin
                out_bundle_o <= in_bundle_i;
                out_pc_o     <= in_pc_i;
            end
        end else if (accept) begin
            if (out_valid_o) begin
                spare_bundle <= in_bundle_i;
                spare_pc     <= in_pc_i;
            end else begin
                out_bundle_o <= in_bundle_i;
                out_pc_o     <= in_pc_i;
            end
        end
    end

endmodule

//--- design/dec_pkg.sv
`include "dec_cfg.svh"

package dec_pkg;

    // Major opcode, instruction bits 6:2
    typedef enum logic [4:0] {
        LOAD     = 5'b00000,
        MISC_MEM = 5'b00011,
        OP_IMM   = 5'b00100,
        AUIPC    = 5'b00101,
        STORE    = 5'b01000,
        OP       = 5'b01100,
        LUI      = 5'b01101,
        BRANCH   = 5'b11000,
        JALR     = 5'b11001,
        JAL      = 5'b11011,
        SYSTEM   = 5'b11100
    } opcode_e;

    // Execution class handed to rename
    typedef enum logic [2:0] {
        UNIT_NONE   = 3'd0,
        UNIT_ALU    = 3'd1,
        UNIT_BRANCH = 3'd2,
        UNIT_LOAD   = 3'd3,
        UNIT_STORE  = 3'd4,
        UNIT_CSR    = 3'd5,
        UNIT_FENCE  = 3'd6
    } unit_e;

    typedef enum logic [2:0] {
        IMM_NONE = 3'd0,
        IMM_I    = 3'd1,
        IMM_S    = 3'd2,
        IMM_B    = 3'd3,
        IMM_U    = 3'd4,
        IMM_J    = 3'd5
    } imm_fmt_e;

    // Causes as encoded in mcause
    typedef enum logic [`EXCP_W-1:0] {
        EXC_NONE       = 0,
        EXC_ILLEGAL    = 2,
        EXC_BREAKPOINT = 3,
        EXC_ECALL_U    = 8,
        EXC_ECALL_M    = 11
    } excp_code_e;

endpackage

//--- design/dec_cfg.svh
`ifndef DEC_CFG_SVH
`define DEC_CFG_SVH

// Fetch bundle holds two 32-bit instructions
`define FETCH_W 64
`define INSN_W  32

// Word PC, bits 31:2 of the byte address
`define PC_W    30

`define XLEN    32
`define REG_AW  5

// Exception cause width, matches mcause low bits
`define EXCP_W  4

`endif
